// ==== hdl/tc_geometry_pkg.sv ====
package tc_geometry_pkg;

	// tiling
	localparam int TILE_DIM = 64;
	localparam int FILTER_GROUP = 32;

	// widths
	localparam int DRAM_AW = 32;
	localparam int MAP_W = 10;
	localparam int TILE_W = 7;
	localparam int KSIZE_W = 4;

	// DRAM word addresses
	localparam logic [DRAM_AW-1:0] WEIGHT_BASE = 32'h0010_0000;
	localparam logic [DRAM_AW-1:0] OUTPUT_BASE = 32'h0018_0000;

	// on-chip memories
	localparam int WSRAM_AW = 13;
	localparam int OSRAM_AW = 18;
	localparam int BUF_AW = 8;
	// row or filter field at the top of both SRAM addresses
	localparam int SLOT_W = 6;
	localparam int WORD_W = WSRAM_AW - SLOT_W;
	localparam int OFS_W = OSRAM_AW - SLOT_W;

	// origin step between neighbouring tiles, 62 for k3 and 60 for k5
	function automatic logic [TILE_W-1:0] tile_step(input logic [KSIZE_W-1:0] k);
		return TILE_W'(TILE_DIM + 1) - TILE_W'(k);
	endfunction

endpackage

// ==== hdl/tc_control_pkg.sv ====
package tc_control_pkg;

	typedef enum logic [3:0] {
		S_IDLE,
		S_WLOAD,
		S_WWAIT,
		S_RLOAD,
		S_RWAIT,
		S_MWAIT,
		S_CWAIT,
		S_OLOAD,
		S_OWAIT,
		S_NTILE,
		S_NGROUP
	} seq_state_t;

	// selects sram type and direction of a DMA request
	typedef enum logic [1:0] {
		DMA_WEIGHT,
		DMA_INPUT,
		DMA_OUTPUT
	} dma_kind_t;

endpackage

// ==== hdl/loop_counters.sv ====
`timescale 1ns/100ps

module loop_counters #(
	parameter int MAX_MAP = 1023,
	parameter int MAX_FILTERS = 1023
) (
	input  logic clk,
	input  logic rst,
	input  logic grp_clr,
	input  logic grp_adv,
	input  logic flt_clr,
	input  logic flt_adv,
	input  logic ch_clr,
	input  logic ch_adv,
	input  logic row_clr,
	input  logic row_adv,
	input  logic orow_clr,
	input  logic orow_adv,
	input  logic tile_clr,
	input  logic tile_adv,
	input  logic [tc_geometry_pkg::KSIZE_W-1:0] kernel_size,
	input  logic [tc_geometry_pkg::MAP_W-1:0] kernel_num,
	input  logic [tc_geometry_pkg::MAP_W-1:0] channel,
	input  logic [tc_geometry_pkg::MAP_W-1:0] map_size,
	output logic [tc_geometry_pkg::MAP_W-1:0] filter_base,
	output logic [tc_geometry_pkg::TILE_W-1:0] filter_idx,
	output logic [tc_geometry_pkg::MAP_W-1:0] channel_idx,
	output logic [tc_geometry_pkg::TILE_W-1:0] row_idx,
	output logic [tc_geometry_pkg::TILE_W-1:0] out_row_idx,
	output logic [tc_geometry_pkg::MAP_W-1:0] tile_col,
	output logic [tc_geometry_pkg::MAP_W-1:0] tile_row,
	output logic [tc_geometry_pkg::TILE_W-1:0] tile_len,
	output logic last_filter,
	output logic last_row,
	output logic last_channel,
	output logic last_out_row,
	output logic last_tile,
	output logic last_group
);

	localparam int MW = tc_geometry_pkg::MAP_W;
	localparam int TW = tc_geometry_pkg::TILE_W;
	localparam int TILE_DIM = tc_geometry_pkg::TILE_DIM;
	localparam int GROUP = tc_geometry_pkg::FILTER_GROUP;

	logic [MW-1:0] filters_left;
	logic [TW-1:0] filter_limit;
	logic [MW-1:0] cols_left;
	logic [MW-1:0] rows_left;
	logic [TW-1:0] row_len;
	logic [TW-1:0] step;

	assign step = tc_geometry_pkg::tile_step(kernel_size);
	assign filters_left = kernel_num - filter_base;
	assign filter_limit = (filters_left > MW'(GROUP)) ? TW'(GROUP) : filters_left[TW-1:0];

	// edge tiles are clipped to the map
	assign cols_left = map_size - tile_col;
	assign rows_left = map_size - tile_row;
	assign tile_len = (cols_left > MW'(TILE_DIM)) ? TW'(TILE_DIM) : cols_left[TW-1:0];
	assign row_len = (rows_left > MW'(TILE_DIM)) ? TW'(TILE_DIM) : rows_left[TW-1:0];

	assign last_group = (filters_left <= MW'(GROUP));
	assign last_filter = (filter_idx == filter_limit - 1'b1);
	assign last_channel = (channel_idx == channel - 1'b1);
	assign last_row = (row_idx == row_len - 1'b1);
	assign last_out_row = (out_row_idx == row_len - kernel_size);
	assign last_tile = (cols_left <= MW'(TILE_DIM)) && (rows_left <= MW'(TILE_DIM));

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			filter_base <= '0;
		else if (grp_clr)
			filter_base <= '0;
		else if (grp_adv)
			filter_base <= filter_base + MW'(GROUP);
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			filter_idx <= '0;
			channel_idx <= '0;
			row_idx <= '0;
			out_row_idx <= '0;
		end
		else
		begin
			if (flt_clr)
				filter_idx <= '0;
			else if (flt_adv)
				filter_idx <= filter_idx + 1'b1;
			if (ch_clr)
				channel_idx <= '0;
			else if (ch_adv)
				channel_idx <= channel_idx + 1'b1;
			if (row_clr)
				row_idx <= '0;
			else if (row_adv)
				row_idx <= row_idx + 1'b1;
			if (orow_clr)
				out_row_idx <= '0;
			else if (orow_adv)
				out_row_idx <= out_row_idx + 1'b1;
		end
	end

	// raster order, left to right then down
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			tile_col <= '0;
			tile_row <= '0;
		end
		else if (tile_clr)
		begin
			tile_col <= '0;
			tile_row <= '0;
		end
		else if (tile_adv && cols_left <= MW'(TILE_DIM))
		begin
			tile_col <= '0;
			tile_row <= tile_row + step;
		end
		else if (tile_adv)
			tile_col <= tile_col + step;
	end

	// weights of one filter must fit a single SRAM row
	assert property (@(posedge clk) disable iff (rst)
		grp_clr |-> ((kernel_size == 4'd3 && channel <= 10'd128) ||
		(kernel_size == 4'd5 && channel <= 10'd42)));

	assert property (@(posedge clk) disable iff (rst)
		grp_clr |-> (map_size <= MAX_MAP && kernel_num <= MAX_FILTERS));

	assert property (@(posedge clk) disable iff (rst)
		tile_adv |=> (tile_col < map_size && tile_row < map_size));

endmodule

// ==== hdl/transfer_sequencer.sv ====
`timescale 1ns/100ps

module transfer_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic dma_done,
	input  logic buf2sram_done,
	input  logic tile_done,
	input  logic last_filter,
	input  logic last_row,
	input  logic last_channel,
	input  logic last_out_row,
	input  logic last_tile,
	input  logic last_group,
	output logic grp_clr,
	output logic grp_adv,
	output logic flt_clr,
	output logic flt_adv,
	output logic ch_clr,
	output logic ch_adv,
	output logic row_clr,
	output logic row_adv,
	output logic orow_clr,
	output logic orow_adv,
	output logic tile_clr,
	output logic tile_adv,
	output logic addr_load,
	output tc_control_pkg::dma_kind_t dma_kind,
	output logic dma_start,
	output logic buf2sram_start,
	output logic compute_run,
	output logic layer_done
);

	tc_control_pkg::seq_state_t state;
	tc_control_pkg::seq_state_t next_state;
	logic run_q;
	logic mover_go;
	logic compute_go;
	logic finish;
	logic dma_busy;

	always_comb
	begin
		next_state = state;
		grp_clr = 1'b0;
		grp_adv = 1'b0;
		flt_clr = 1'b0;
		flt_adv = 1'b0;
		ch_clr = 1'b0;
		ch_adv = 1'b0;
		row_clr = 1'b0;
		row_adv = 1'b0;
		orow_clr = 1'b0;
		orow_adv = 1'b0;
		tile_clr = 1'b0;
		tile_adv = 1'b0;
		addr_load = 1'b0;
		dma_kind = tc_control_pkg::DMA_WEIGHT;
		mover_go = 1'b0;
		compute_go = 1'b0;
		finish = 1'b0;
		case (state)
			tc_control_pkg::S_IDLE:
				if (run_q)
				begin
					grp_clr = 1'b1;
					flt_clr = 1'b1;
					tile_clr = 1'b1;
					next_state = tc_control_pkg::S_WLOAD;
				end
			tc_control_pkg::S_WLOAD:
			begin
				addr_load = 1'b1;
				dma_kind = tc_control_pkg::DMA_WEIGHT;
				next_state = tc_control_pkg::S_WWAIT;
			end
			tc_control_pkg::S_WWAIT:
				if (dma_done && last_filter)
				begin
					ch_clr = 1'b1;
					row_clr = 1'b1;
					next_state = tc_control_pkg::S_RLOAD;
				end
				else if (dma_done)
				begin
					flt_adv = 1'b1;
					next_state = tc_control_pkg::S_WLOAD;
				end
			tc_control_pkg::S_RLOAD:
			begin
				addr_load = 1'b1;
				dma_kind = tc_control_pkg::DMA_INPUT;
				next_state = tc_control_pkg::S_RWAIT;
			end
			tc_control_pkg::S_RWAIT:
				if (dma_done)
				begin
					mover_go = 1'b1;
					next_state = tc_control_pkg::S_MWAIT;
				end
			tc_control_pkg::S_MWAIT:
				if (buf2sram_done && last_row)
				begin
					compute_go = 1'b1;
					next_state = tc_control_pkg::S_CWAIT;
				end
				else if (buf2sram_done)
				begin
					row_adv = 1'b1;
					next_state = tc_control_pkg::S_RLOAD;
				end
			tc_control_pkg::S_CWAIT:
				if (tile_done && last_channel)
				begin
					flt_clr = 1'b1;
					orow_clr = 1'b1;
					next_state = tc_control_pkg::S_OLOAD;
				end
				else if (tile_done)
				begin
					ch_adv = 1'b1;
					row_clr = 1'b1;
					next_state = tc_control_pkg::S_RLOAD;
				end
			tc_control_pkg::S_OLOAD:
			begin
				addr_load = 1'b1;
				dma_kind = tc_control_pkg::DMA_OUTPUT;
				next_state = tc_control_pkg::S_OWAIT;
			end
			tc_control_pkg::S_OWAIT:
				if (dma_done && !last_out_row)
				begin
					orow_adv = 1'b1;
					next_state = tc_control_pkg::S_OLOAD;
				end
				else if (dma_done && !last_filter)
				begin
					flt_adv = 1'b1;
					orow_clr = 1'b1;
					next_state = tc_control_pkg::S_OLOAD;
				end
				else if (dma_done && last_tile)
					next_state = tc_control_pkg::S_NGROUP;
				else if (dma_done)
					next_state = tc_control_pkg::S_NTILE;
			tc_control_pkg::S_NTILE:
			begin
				tile_adv = 1'b1;
				ch_clr = 1'b1;
				row_clr = 1'b1;
				next_state = tc_control_pkg::S_RLOAD;
			end
			tc_control_pkg::S_NGROUP:
				if (last_group)
				begin
					finish = 1'b1;
					next_state = tc_control_pkg::S_IDLE;
				end
				else
				begin
					grp_adv = 1'b1;
					flt_clr = 1'b1;
					tile_clr = 1'b1;
					next_state = tc_control_pkg::S_WLOAD;
				end
			default:
				next_state = tc_control_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= tc_control_pkg::S_IDLE;
			run_q <= 1'b0;
			dma_start <= 1'b0;
			buf2sram_start <= 1'b0;
			compute_run <= 1'b0;
			layer_done <= 1'b0;
		end
		else
		begin
			state <= next_state;
			run_q <= run;
			// addresses are registered with addr_load, start goes out a cycle later
			dma_start <= addr_load;
			buf2sram_start <= mover_go;
			compute_run <= compute_go;
			layer_done <= finish;
		end
	end

	// one DMA request in flight
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			dma_busy <= 1'b0;
		else if (dma_start)
			dma_busy <= 1'b1;
		else if (dma_done)
			dma_busy <= 1'b0;
	end

	assert property (@(posedge clk) disable iff (rst) dma_start |-> !dma_busy);

endmodule

// ==== hdl/dram_addr_gen.sv ====
`timescale 1ns/100ps

module dram_addr_gen (
	input  logic clk,
	input  logic rst,
	input  logic addr_load,
	input  tc_control_pkg::dma_kind_t dma_kind,
	input  logic [tc_geometry_pkg::MAP_W-1:0] filter_base,
	input  logic [tc_geometry_pkg::TILE_W-1:0] filter_idx,
	input  logic [tc_geometry_pkg::MAP_W-1:0] channel_idx,
	input  logic [tc_geometry_pkg::TILE_W-1:0] row_idx,
	input  logic [tc_geometry_pkg::TILE_W-1:0] out_row_idx,
	input  logic [tc_geometry_pkg::MAP_W-1:0] tile_col,
	input  logic [tc_geometry_pkg::MAP_W-1:0] tile_row,
	input  logic [tc_geometry_pkg::TILE_W-1:0] tile_len,
	input  logic [tc_geometry_pkg::KSIZE_W-1:0] kernel_size,
	input  logic [tc_geometry_pkg::MAP_W-1:0] channel,
	input  logic [tc_geometry_pkg::MAP_W-1:0] map_size,
	output logic [tc_geometry_pkg::DRAM_AW-1:0] dma_dram_start,
	output logic [tc_geometry_pkg::DRAM_AW-1:0] dma_dram_end,
	output logic dma_sram_type,
	output logic dma_dir
);

	localparam int AW = tc_geometry_pkg::DRAM_AW;

	logic [AW-1:0] out_dim;
	logic [AW-1:0] filter_num;
	logic [AW-1:0] filter_words;
	logic [AW-1:0] word_start;
	logic [AW-1:0] word_last;

	// stride 1, no padding
	assign out_dim = map_size - kernel_size + 1'b1;
	assign filter_num = filter_base + filter_idx;
	assign filter_words = kernel_size * kernel_size * channel;

	always_comb
	begin
		case (dma_kind)
			tc_control_pkg::DMA_WEIGHT:
			begin
				word_start = tc_geometry_pkg::WEIGHT_BASE + filter_num * filter_words;
				word_last = word_start + filter_words - 1'b1;
			end
			tc_control_pkg::DMA_INPUT:
			begin
				word_start = channel_idx * map_size * map_size +
					(tile_row + row_idx) * map_size + tile_col;
				word_last = word_start + tile_len - 1'b1;
			end
			tc_control_pkg::DMA_OUTPUT:
			begin
				word_start = tc_geometry_pkg::OUTPUT_BASE + filter_num * out_dim * out_dim +
					(out_row_idx + tile_row) * out_dim + tile_col;
				word_last = word_start + tile_len - kernel_size;
			end
			default:
			begin
				word_start = '0;
				word_last = '0;
			end
		endcase
	end

	// byte addresses
	always_ff @(posedge clk)
	begin
		if (addr_load)
		begin
			dma_dram_start <= {word_start[AW-3:0], 2'b00};
			dma_dram_end <= {word_last[AW-3:0], 2'b00};
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			dma_sram_type <= 1'b0;
			dma_dir <= 1'b0;
		end
		else if (addr_load)
		begin
			dma_sram_type <= (dma_kind == tc_control_pkg::DMA_WEIGHT);
			dma_dir <= (dma_kind == tc_control_pkg::DMA_OUTPUT);
		end
	end

endmodule

// ==== hdl/sram_addr_gen.sv ====
`timescale 1ns/100ps

module sram_addr_gen (
	input  logic clk,
	input  logic rst,
	input  logic addr_load,
	input  tc_control_pkg::dma_kind_t dma_kind,
	input  logic [tc_geometry_pkg::TILE_W-1:0] filter_idx,
	input  logic [tc_geometry_pkg::MAP_W-1:0] channel_idx,
	input  logic [tc_geometry_pkg::TILE_W-1:0] row_idx,
	input  logic [tc_geometry_pkg::TILE_W-1:0] out_row_idx,
	input  logic [tc_geometry_pkg::TILE_W-1:0] tile_len,
	input  logic [tc_geometry_pkg::KSIZE_W-1:0] kernel_size,
	input  logic [tc_geometry_pkg::MAP_W-1:0] channel,
	output logic [tc_geometry_pkg::WSRAM_AW-1:0] weight_sram_start,
	output logic [tc_geometry_pkg::WSRAM_AW-1:0] weight_sram_end,
	output logic [tc_geometry_pkg::OSRAM_AW-1:0] output_sram_start,
	output logic [tc_geometry_pkg::OSRAM_AW-1:0] output_sram_end,
	output logic [tc_geometry_pkg::BUF_AW-1:0] buf_start,
	output logic [tc_geometry_pkg::BUF_AW-1:0] buf_end,
	output logic [tc_geometry_pkg::WSRAM_AW-1:0] input_sram_start
);

	localparam int SW = tc_geometry_pkg::SLOT_W;
	localparam int WW = tc_geometry_pkg::WORD_W;
	localparam int OW = tc_geometry_pkg::OFS_W;
	localparam int TW = tc_geometry_pkg::TILE_W;

	logic weight_load;
	logic input_load;
	logic output_load;
	logic [tc_geometry_pkg::MAP_W-1:0] weight_len_m1;
	logic [TW-1:0] buf_words;
	logic [OW-1:0] orow_ofs;
	logic [OW-1:0] orow_last;
	logic buf_half;
	logic half_next;
	logic [tc_geometry_pkg::MAP_W-1:0] prev_ch;

	assign weight_load = addr_load && (dma_kind == tc_control_pkg::DMA_WEIGHT);
	assign input_load = addr_load && (dma_kind == tc_control_pkg::DMA_INPUT);
	assign output_load = addr_load && (dma_kind == tc_control_pkg::DMA_OUTPUT);

	// k5 packs one filter channel into three words
	assign weight_len_m1 = (kernel_size == 4'd3) ? channel - 1'b1 : channel * 2'd3 - 1'b1;
	// four pixels per buffer word
	assign buf_words = (tile_len + 2'd3) >> 2;
	assign orow_ofs = out_row_idx * tc_geometry_pkg::tile_step(kernel_size);
	assign orow_last = orow_ofs + tile_len - kernel_size;

	// ping-pong half flips with each new channel
	assign half_next = (row_idx == '0) ? ~buf_half : buf_half;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			buf_half <= 1'b1;
		else if (input_load)
			buf_half <= half_next;
	end

	always_ff @(posedge clk)
	begin
		if (weight_load)
		begin
			weight_sram_start <= {filter_idx[SW-1:0], {WW{1'b0}}};
			weight_sram_end <= {filter_idx[SW-1:0], weight_len_m1[WW-1:0]};
		end
		if (input_load)
		begin
			buf_start <= {half_next, {(tc_geometry_pkg::BUF_AW-1){1'b0}}};
			buf_end <= {half_next, buf_words - 1'b1};
			input_sram_start <= {row_idx[SW-1:0], {WW{1'b0}}};
			prev_ch <= channel_idx;
		end
		if (output_load)
		begin
			output_sram_start <= {filter_idx[SW-1:0], orow_ofs};
			output_sram_end <= {filter_idx[SW-1:0], orow_last};
		end
	end

	// a channel change must land on row 0, otherwise the halves drift
	assert property (@(posedge clk) disable iff (rst)
		(input_load && channel_idx != prev_ch) |-> (row_idx == '0));

endmodule

// ==== hdl/transfer_controller.sv ====
`timescale 1ns/100ps

module transfer_controller #(
	parameter int MAX_MAP = 1023,
	parameter int MAX_FILTERS = 1023
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic dma_done,
	input  logic buf2sram_done,
	input  logic tile_done,
	input  logic [tc_geometry_pkg::KSIZE_W-1:0] kernel_size,
	input  logic [tc_geometry_pkg::MAP_W-1:0] kernel_num,
	input  logic [tc_geometry_pkg::MAP_W-1:0] channel,
	input  logic [tc_geometry_pkg::MAP_W-1:0] map_size,
	output logic dma_start,
	output logic dma_sram_type,
	output logic dma_dir,
	output logic [tc_geometry_pkg::DRAM_AW-1:0] dma_dram_start,
	output logic [tc_geometry_pkg::DRAM_AW-1:0] dma_dram_end,
	output logic [tc_geometry_pkg::WSRAM_AW-1:0] weight_sram_start,
	output logic [tc_geometry_pkg::WSRAM_AW-1:0] weight_sram_end,
	output logic [tc_geometry_pkg::OSRAM_AW-1:0] output_sram_start,
	output logic [tc_geometry_pkg::OSRAM_AW-1:0] output_sram_end,
	output logic [tc_geometry_pkg::BUF_AW-1:0] buf_start,
	output logic [tc_geometry_pkg::BUF_AW-1:0] buf_end,
	output logic [tc_geometry_pkg::WSRAM_AW-1:0] input_sram_start,
	output logic buf2sram_start,
	output logic compute_run,
	output logic layer_done
);

	// loop commands
	logic grp_clr;
	logic grp_adv;
	logic flt_clr;
	logic flt_adv;
	logic ch_clr;
	logic ch_adv;
	logic row_clr;
	logic row_adv;
	logic orow_clr;
	logic orow_adv;
	logic tile_clr;
	logic tile_adv;

	// loop state
	logic [tc_geometry_pkg::MAP_W-1:0] filter_base;
	logic [tc_geometry_pkg::TILE_W-1:0] filter_idx;
	logic [tc_geometry_pkg::MAP_W-1:0] channel_idx;
	logic [tc_geometry_pkg::TILE_W-1:0] row_idx;
	logic [tc_geometry_pkg::TILE_W-1:0] out_row_idx;
	logic [tc_geometry_pkg::MAP_W-1:0] tile_col;
	logic [tc_geometry_pkg::MAP_W-1:0] tile_row;
	logic [tc_geometry_pkg::TILE_W-1:0] tile_len;
	logic last_filter;
	logic last_row;
	logic last_channel;
	logic last_out_row;
	logic last_tile;
	logic last_group;

	logic addr_load;
	tc_control_pkg::dma_kind_t dma_kind;

	transfer_sequencer u_sequencer (.*);

	loop_counters #(
		.MAX_MAP(MAX_MAP),
		.MAX_FILTERS(MAX_FILTERS)
	) u_loop_counters (.*);

	dram_addr_gen u_dram_addr_gen (.*);

	sram_addr_gen u_sram_addr_gen (.*);

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

// ==== sim/tb_transfer_controller.sv ====
`timescale 1ns/100ps

module tb_transfer_controller;

	localparam int CLK_NS = 40;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_REQ = 40;
	localparam int MAX_LAYERS = 16;
	localparam int GROUP = tc_geometry_pkg::FILTER_GROUP;
	localparam int TILE = tc_geometry_pkg::TILE_DIM;
	localparam logic [3:0] P_DMA = 4'b0001;
	localparam logic [3:0] P_MOVER = 4'b0010;
	localparam logic [3:0] P_COMPUTE = 4'b0100;
	localparam logic [3:0] P_DONE = 4'b1000;

	logic clk;
	logic rst;
	logic run;
	logic dma_done;
	logic buf2sram_done;
	logic tile_done;
	logic [tc_geometry_pkg::KSIZE_W-1:0] kernel_size;
	logic [tc_geometry_pkg::MAP_W-1:0] kernel_num;
	logic [tc_geometry_pkg::MAP_W-1:0] channel;
	logic [tc_geometry_pkg::MAP_W-1:0] map_size;
	logic dma_start;
	logic dma_sram_type;
	logic dma_dir;
	logic [tc_geometry_pkg::DRAM_AW-1:0] dma_dram_start;
	logic [tc_geometry_pkg::DRAM_AW-1:0] dma_dram_end;
	logic [tc_geometry_pkg::WSRAM_AW-1:0] weight_sram_start;
	logic [tc_geometry_pkg::WSRAM_AW-1:0] weight_sram_end;
	logic [tc_geometry_pkg::OSRAM_AW-1:0] output_sram_start;
	logic [tc_geometry_pkg::OSRAM_AW-1:0] output_sram_end;
	logic [tc_geometry_pkg::BUF_AW-1:0] buf_start;
	logic [tc_geometry_pkg::BUF_AW-1:0] buf_end;
	logic [tc_geometry_pkg::WSRAM_AW-1:0] input_sram_start;
	logic buf2sram_start;
	logic compute_run;
	logic layer_done;

	// layers from the input file
	int lay_k[MAX_LAYERS];
	int lay_f[MAX_LAYERS];
	int lay_c[MAX_LAYERS];
	int lay_m[MAX_LAYERS];
	int lay_nw[MAX_LAYERS];
	int lay_ni[MAX_LAYERS];
	int lay_nc[MAX_LAYERS];
	int lay_no[MAX_LAYERS];
	int num_layers;
	longint wdog_ns;

	int cur_k;
	int cur_f;
	int cur_c;
	int cur_m;
	int cur_o;
	int cur_step;
	int cnt_weight;
	int cnt_input;
	int cnt_move;
	int cnt_compute;
	int cnt_output;
	int buf_half;
	logic [31:0] lfsr_state;

	tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clock_gen (.clk(clk));

	transfer_controller u_dut (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// taps 32, 22, 2, 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int val;
		int i;
		val = 0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | lfsr_state[0];
		end
		return val;
	endfunction

	function automatic int smaller(input int a, input int b);
		return (a < b) ? a : b;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// tally every request the DUT issues by kind
	task automatic count_requests();
		if (dma_start && dma_sram_type)
			cnt_weight++;
		else if (dma_start && dma_dir)
			cnt_output++;
		else if (dma_start)
			cnt_input++;
		if (buf2sram_start)
			cnt_move++;
		if (compute_run)
			cnt_compute++;
	endtask

	// inputs change 2 ns after each edge and done pulses drop
	task automatic next_cycle();
		@(posedge clk);
		#2;
		count_requests();
		run = 1'b0;
		dma_done = 1'b0;
		buf2sram_done = 1'b0;
		tile_done = 1'b0;
	endtask

	task automatic wait_pulse(input logic [3:0] want, input string what);
		logic [3:0] seen;
		seen = 4'b0000;
		while (seen == 4'b0000)
		begin
			next_cycle();
			seen = {layer_done, compute_run, buf2sram_start, dma_start};
		end
		check_value({"start pulses for ", what}, seen, want);
	endtask

	// engine stays busy 1 to 8 cycles while nothing may start
	task automatic reply_late(input int engine);
		int busy;
		busy = 1 + random_bits(3);
		repeat (busy)
		begin
			next_cycle();
			check_value("start pulses while busy",
				{layer_done, compute_run, buf2sram_start, dma_start}, 4'b0000);
		end
		case (engine)
			0: dma_done = 1'b1;
			1: buf2sram_done = 1'b1;
			default: tile_done = 1'b1;
		endcase
	endtask

	task automatic expect_weight(input int fnum, input int f);
		int words;
		int start;
		words = cur_k * cur_k * cur_c;
		start = (tc_geometry_pkg::WEIGHT_BASE + fnum * words) * 4;
		wait_pulse(P_DMA, "weight load");
		check_value("weight dram start", dma_dram_start, start);
		check_value("weight dram end", dma_dram_end, start + (words - 1) * 4);
		check_value("weight sram type", dma_sram_type, 1);
		check_value("weight dir", dma_dir, 0);
		check_value("weight sram start", weight_sram_start, f * 128);
		check_value("weight sram end", weight_sram_end,
			f * 128 + ((cur_k == 3) ? cur_c - 1 : 3 * cur_c - 1));
		reply_late(0);
	endtask

	task automatic expect_input(input int c, input int r, input int tr, input int tc,
		input int tlen);
		int start;
		start = (c * cur_m * cur_m + (tr + r) * cur_m + tc) * 4;
		if (r == 0)
			buf_half = 1 - buf_half;
		wait_pulse(P_DMA, "row load");
		check_value("row dram start", dma_dram_start, start);
		check_value("row dram end", dma_dram_end, start + (tlen - 1) * 4);
		check_value("row sram type", dma_sram_type, 0);
		check_value("row dir", dma_dir, 0);
		reply_late(0);
		wait_pulse(P_MOVER, "row move");
		check_value("buffer start", buf_start, buf_half * 128);
		check_value("buffer end", buf_end, buf_half * 128 + (tlen + 3) / 4 - 1);
		check_value("input sram start", input_sram_start, r * 128);
		reply_late(1);
	endtask

	task automatic expect_output(input int fnum, input int f, input int o, input int tr,
		input int tc, input int tlen);
		int start;
		int ofs;
		start = (tc_geometry_pkg::OUTPUT_BASE + fnum * cur_o * cur_o +
			(o + tr) * cur_o + tc) * 4;
		ofs = f * 4096 + o * cur_step;
		wait_pulse(P_DMA, "output store");
		check_value("output dram start", dma_dram_start, start);
		check_value("output dram end", dma_dram_end, start + (tlen - cur_k) * 4);
		check_value("output sram type", dma_sram_type, 0);
		check_value("output dir", dma_dir, 1);
		check_value("output sram start", output_sram_start, ofs);
		check_value("output sram end", output_sram_end, ofs + tlen - cur_k);
		reply_late(0);
	endtask

	task automatic run_tile(input int g, input int flimit, input int tr, input int tc,
		input int rlen, input int tlen);
		int c;
		int r;
		int f;
		int o;
		for (c = 0; c < cur_c; c++)
		begin
			for (r = 0; r < rlen; r++)
				expect_input(c, r, tr, tc, tlen);
			// compute only after the last row of the channel has moved
			wait_pulse(P_COMPUTE, "compute");
			reply_late(2);
		end
		for (f = 0; f < flimit; f++)
			for (o = 0; o <= rlen - cur_k; o++)
				expect_output(g * GROUP + f, f, o, tr, tc, tlen);
	endtask

	task automatic run_layer(input int li);
		int g;
		int flimit;
		int f;
		int tr;
		int tc;
		bit last_col;
		bit last_row;
		cur_k = lay_k[li];
		cur_f = lay_f[li];
		cur_c = lay_c[li];
		cur_m = lay_m[li];
		cur_o = cur_m - cur_k + 1;
		cur_step = TILE + 1 - cur_k;
		cnt_weight = 0;
		cnt_input = 0;
		cnt_move = 0;
		cnt_compute = 0;
		cnt_output = 0;
		kernel_size = cur_k;
		kernel_num = cur_f;
		channel = cur_c;
		map_size = cur_m;
		run = 1'b1;
		for (g = 0; g * GROUP < cur_f; g++)
		begin
			flimit = smaller(GROUP, cur_f - g * GROUP);
			for (f = 0; f < flimit; f++)
				expect_weight(g * GROUP + f, f);
			tr = 0;
			do
			begin
				last_row = (cur_m - tr <= TILE);
				tc = 0;
				do
				begin
					last_col = (cur_m - tc <= TILE);
					run_tile(g, flimit, tr, tc, smaller(TILE, cur_m - tr),
						smaller(TILE, cur_m - tc));
					tc += cur_step;
				end
				while (!last_col);
				tr += cur_step;
			end
			while (!last_row);
		end
		wait_pulse(P_DONE, "layer end");
		check_value("weight requests", cnt_weight, lay_nw[li]);
		check_value("row requests", cnt_input, lay_ni[li]);
		check_value("move requests", cnt_move, lay_ni[li]);
		check_value("compute pulses", cnt_compute, lay_nc[li]);
		check_value("output requests", cnt_output, lay_no[li]);
	endtask

	task automatic read_layers();
		int fd;
		int n;
		int v[8];
		string line;
		num_layers = 0;
		fd = $fopen("sim/tc_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the layer file sim/tc_input.txt");
			$display("Test FAILED");
			$fatal(1, "no input file");
		end
		while (!$feof(fd) && num_layers < MAX_LAYERS)
		begin
			line = "";
			void'($fgets(line, fd));
			n = 0;
			if (line.len() > 0 && line[0] != "#")
				n = $sscanf(line, "%d %d %d %d %d %d %d %d",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
			if (n == 8)
			begin
				lay_k[num_layers] = v[0];
				lay_f[num_layers] = v[1];
				lay_c[num_layers] = v[2];
				lay_m[num_layers] = v[3];
				lay_nw[num_layers] = v[4];
				lay_ni[num_layers] = v[5];
				lay_nc[num_layers] = v[6];
				lay_no[num_layers] = v[7];
				num_layers++;
			end
		end
		$fclose(fd);
	endtask

	// watchdog sized from the request counts of all layers
	initial
	begin
		wait (wdog_ns > 0);
		#(wdog_ns);
		$display("timeout, the controller stopped making progress at %0t ns", $time);
		$display("Test FAILED");
		$fatal(1, "watchdog");
	end

	initial
	begin
		longint total;
		rst = 1'b1;
		run = 1'b0;
		dma_done = 1'b0;
		buf2sram_done = 1'b0;
		tile_done = 1'b0;
		kernel_size = 4'd3;
		kernel_num = 10'd1;
		channel = 10'd1;
		map_size = 10'd8;
		// ping-pong half comes out of reset at 1
		buf_half = 1;
		lfsr_state = 32'h39a0ff52;
		wdog_ns = 0;
		read_layers();
		if (num_layers == 0)
		begin
			$display("the layer file sim/tc_input.txt holds no test layers");
			$display("Test FAILED");
			$fatal(1, "empty input file");
		end
		total = 0;
		for (int i = 0; i < num_layers; i++)
			total += lay_nw[i] + lay_ni[i] + lay_nc[i] + lay_no[i];
		wdog_ns = (RESET_CYCLES + 10 * num_layers + total * CYCLES_PER_REQ) * CLK_NS;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < num_layers; i++)
			run_layer(i);
		// controller stays quiet once the last layer is done
		repeat (4)
		begin
			next_cycle();
			check_value("start pulses after the last layer",
				{layer_done, compute_run, buf2sram_start, dma_start}, 4'b0000);
		end
		$display("Test OK");
		$finish;
	end

endmodule

// ==== sim/tc_input.txt ====
# kernel filters channels map_size, then expected counts of
# weight requests, row requests, compute pulses and output requests
3 4 2 8 4 16 2 24
5 34 1 6 34 12 2 68
3 2 1 70 2 144 4 272
5 1 2 66 1 280 8 124
3 33 128 4 33 1024 256 66
5 3 42 5 3 210 42 3

// ==== transfer_controller.f ====
hdl/tc_geometry_pkg.sv
hdl/tc_control_pkg.sv
hdl/loop_counters.sv
hdl/transfer_sequencer.sv
hdl/dram_addr_gen.sv
hdl/sram_addr_gen.sv
hdl/transfer_controller.sv
sim/tb_clock_gen.sv
sim/tb_transfer_controller.sv

// ==== Bender.yml ====
package:
  name: transfer_controller

sources:
  - files:
      - hdl/tc_geometry_pkg.sv
      - hdl/tc_control_pkg.sv
      - hdl/loop_counters.sv
      - hdl/transfer_sequencer.sv
      - hdl/dram_addr_gen.sv
      - hdl/sram_addr_gen.sv
      - hdl/transfer_controller.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_transfer_controller.sv
